// ==== build.f ====
source/eth_pkg.sv
source/eth_buf_if.sv
source/eth_host_regs.sv
source/eth_pkt_buf.sv
source/eth_mii_tx.sv
source/eth_mii_rx.sv
source/eth_core.sv
test/eth_core_tb.sv

// ==== source/eth_buf_if.sv ====
interface eth_buf_if #(
   parameter int BUF_ADDR_W = 11
);

   // write port
   logic [BUF_ADDR_W-1:0] wr_addr;
   logic [7:0]            wr_data;
   logic                  wr_en;

   // read port, data follows the address by one cycle
   logic [BUF_ADDR_W-1:0] rd_addr;
   logic [7:0]            rd_data;

   modport writer (
      output wr_addr, wr_data, wr_en
   );

   modport reader (
      output rd_addr,
      input  rd_data
   );

   modport mem (
      input  wr_addr, wr_data, wr_en, rd_addr,
      output rd_data
   );

endinterface

// ==== source/eth_core.sv ====
module eth_core
   import eth_pkg::*;
#(
   parameter int BUF_ADDR_W     = 11,
   parameter int PHY_RST_CYCLES = 64
) (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   sel,
   input  logic                   we,
   input  logic [host_addr_w-1:0] addr,
   input  logic [host_data_w-1:0] data_in,
   output logic [host_data_w-1:0] data_out,
   output logic                   phy_resetn,
   input  logic                   rx_dv,
   input  logic [3:0]             rx_data,
   output logic                   tx_en,
   output logic [3:0]             tx_data
);

   logic                send;
   logic                receive;
   logic [nbytes_w-1:0] tx_nbytes;
   logic [nbytes_w-1:0] rx_nbytes;
   logic                tx_busy;
   logic                rx_busy;

   eth_buf_if #(.BUF_ADDR_W(BUF_ADDR_W)) tx_buf ();
   eth_buf_if #(.BUF_ADDR_W(BUF_ADDR_W)) rx_buf ();

   eth_host_regs #(.BUF_ADDR_W(BUF_ADDR_W), .PHY_RST_CYCLES(PHY_RST_CYCLES)) regs_i (
      .clk, .rst, .sel, .we, .addr, .data_in, .data_out, .phy_resetn,
      .send, .receive, .tx_nbytes, .rx_nbytes, .tx_busy, .rx_busy,
      .tx_buf(tx_buf.writer),
      .rx_buf(rx_buf.reader)
   );

   // host fills this one, the transmitter drains it
   eth_pkt_buf #(.BUF_ADDR_W(BUF_ADDR_W)) tx_buf_i (.clk, .buf_if(tx_buf.mem));

   // receiver fills this one, the host reads it back
   eth_pkt_buf #(.BUF_ADDR_W(BUF_ADDR_W)) rx_buf_i (.clk, .buf_if(rx_buf.mem));

   eth_mii_tx #(.BUF_ADDR_W(BUF_ADDR_W)) mii_tx_i (
      .clk, .rst, .send,
      .nbytes(tx_nbytes),
      .busy(tx_busy),
      .tx_en, .tx_data,
      .buf_if(tx_buf.reader)
   );

   eth_mii_rx #(.BUF_ADDR_W(BUF_ADDR_W)) mii_rx_i (
      .clk, .rst, .receive,
      .nbytes(rx_nbytes),
      .rx_dv, .rx_data,
      .busy(rx_busy),
      .buf_if(rx_buf.writer)
   );

endmodule

// ==== source/eth_host_regs.sv ====
module eth_host_regs
   import eth_pkg::*;
#(
   parameter int BUF_ADDR_W     = 11,
   parameter int PHY_RST_CYCLES = 64
) (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   sel,
   input  logic                   we,
   input  logic [host_addr_w-1:0] addr,
   input  logic [host_data_w-1:0] data_in,
   output logic [host_data_w-1:0] data_out,
   output logic                   phy_resetn,
   output logic                   send,
   output logic                   receive,
   output logic [nbytes_w-1:0]    tx_nbytes,
   output logic [nbytes_w-1:0]    rx_nbytes,
   input  logic                   tx_busy,
   input  logic                   rx_busy,
   eth_buf_if.writer              tx_buf,
   eth_buf_if.reader              rx_buf
);

   localparam int phy_cnt_w = (PHY_RST_CYCLES > 1) ? $clog2(PHY_RST_CYCLES) : 1;

   host_word_u             word;
   logic                   buf_win;
   logic                   reg_wr;
   logic                   rd_req;
   logic                   tx_ready;
   logic                   rx_ready;
   logic [host_data_w-1:0] scratch;
   logic [host_data_w-1:0] reg_rd_data;
   logic [host_data_w-1:0] reg_rd_q;
   logic                   buf_rd_q;
   logic [BUF_ADDR_W-1:0]  rd_addr_q;
   logic [phy_cnt_w-1:0]   phy_cnt;

   assign word    = data_in;
   assign buf_win = addr[host_addr_w-1];
   assign reg_wr  = sel && we && !buf_win;
   assign rd_req  = sel && !we;

   // control strobes, one per control write
   assign send    = reg_wr && (addr == reg_control) && word.ctrl.send;
   assign receive = reg_wr && (addr == reg_control) && word.ctrl.receive;

   assign tx_ready = phy_resetn && !tx_busy;
   assign rx_ready = phy_resetn && !rx_busy;

   assign tx_buf.wr_en   = sel && we && buf_win;
   assign tx_buf.wr_addr = addr[BUF_ADDR_W-1:0];
   assign tx_buf.wr_data = data_in[7:0];

   // hold the last buffer address so rd_data stays put between reads
   assign rx_buf.rd_addr = (rd_req && buf_win) ? addr[BUF_ADDR_W-1:0] : rd_addr_q;

   always_comb begin
      case (addr)
         reg_status:    reg_rd_data = {{(host_data_w-3){1'b0}}, phy_resetn, rx_ready, tx_ready};
         reg_scratch:   reg_rd_data = scratch;
         reg_tx_nbytes: reg_rd_data = {{(host_data_w-nbytes_w){1'b0}}, tx_nbytes};
         reg_rx_nbytes: reg_rd_data = {{(host_data_w-nbytes_w){1'b0}}, rx_nbytes};
         default:       reg_rd_data = '0;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         scratch   <= '0;
         tx_nbytes <= '0;
         rx_nbytes <= '0;
         reg_rd_q  <= '0;
         buf_rd_q  <= 1'b0;
         rd_addr_q <= '0;
      end else begin
         if (reg_wr && addr == reg_scratch) scratch <= data_in;
         if (reg_wr && addr == reg_tx_nbytes) tx_nbytes <= word.count.nbytes;
         if (reg_wr && addr == reg_rx_nbytes) rx_nbytes <= word.count.nbytes;
         if (rd_req) begin
            reg_rd_q <= reg_rd_data;
            buf_rd_q <= buf_win;
            if (buf_win) rd_addr_q <= addr[BUF_ADDR_W-1:0];
         end
      end
   end

   // buffer reads come straight from the synchronous memory output
   assign data_out = buf_rd_q ? {{(host_data_w-8){1'b0}}, rx_buf.rd_data} : reg_rd_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         phy_cnt    <= '0;
         phy_resetn <= 1'b0;
      end else if (!phy_resetn) begin
         if (phy_cnt == phy_cnt_w'(PHY_RST_CYCLES - 1)) phy_resetn <= 1'b1;
         else phy_cnt <= phy_cnt + 1'b1;
      end
   end

   // neither mii engine may start before the phy leaves reset
   assert property (@(posedge clk) disable iff (rst)
      !phy_resetn |-> !send && !receive && !tx_busy && !rx_busy);

endmodule

// ==== source/eth_mii_rx.sv ====
module eth_mii_rx
   import eth_pkg::*;
#(
   parameter int BUF_ADDR_W = 11
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                receive,
   input  logic [nbytes_w-1:0] nbytes,
   input  logic                rx_dv,
   input  logic [3:0]          rx_data,
   output logic                busy,
   eth_buf_if.writer           buf_if
);

   typedef enum logic [1:0] {st_idle, st_hunt, st_assemble} rx_state_t;

   rx_state_t           state;
   logic                rx_dv_q;
   logic [3:0]          rx_data_q;
   logic                phase;
   logic [3:0]          lo_nib;
   logic [nbytes_w-1:0] nbytes_q;
   logic [nbytes_w-1:0] byte_cnt;
   logic                byte_done;

   // second nibble of a byte while the frame is still valid
   assign byte_done = (state == st_assemble) && rx_dv_q && phase;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state        <= st_idle;
         busy         <= 1'b0;
         rx_dv_q      <= 1'b0;
         phase        <= 1'b0;
         nbytes_q     <= '0;
         byte_cnt     <= '0;
         buf_if.wr_en <= 1'b0;
      end else begin
         rx_dv_q      <= rx_dv;
         buf_if.wr_en <= byte_done;
         case (state)
            st_idle: begin
               busy <= 1'b0;
               if (receive && !busy && nbytes != '0) begin
                  busy     <= 1'b1;
                  nbytes_q <= nbytes;
                  byte_cnt <= '0;
                  state    <= st_hunt;
               end
            end
            st_hunt: begin
               phase <= 1'b0;
               if (rx_dv_q && rx_data_q == mii_sfd) state <= st_assemble;
            end
            st_assemble: begin
               phase <= !phase;
               if (!rx_dv_q) state <= st_idle;
               else if (phase) begin
                  byte_cnt <= byte_cnt + 1'b1;
                  if (byte_cnt + 1'b1 == nbytes_q) state <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // input register and byte assembly, low nibble first
   always_ff @(posedge clk) begin
      rx_data_q <= rx_data;
      if (state == st_assemble && !phase) lo_nib <= rx_data_q;
      if (byte_done) begin
         buf_if.wr_data <= {rx_data_q, lo_nib};
         buf_if.wr_addr <= byte_cnt[BUF_ADDR_W-1:0];
      end
   end

   assert property (@(posedge clk) disable iff (rst) buf_if.wr_en |-> busy);

endmodule

// ==== source/eth_mii_tx.sv ====
module eth_mii_tx
   import eth_pkg::*;
#(
   parameter int BUF_ADDR_W = 11
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                send,
   input  logic [nbytes_w-1:0] nbytes,
   output logic                busy,
   output logic                tx_en,
   output logic [3:0]          tx_data,
   eth_buf_if.reader           buf_if
);

   typedef enum logic [2:0] {st_idle, st_preamble, st_sfd, st_low, st_high} tx_state_t;

   tx_state_t           state;
   logic [3:0]          pre_cnt;
   logic [nbytes_w-1:0] nbytes_q;
   logic [nbytes_w-1:0] byte_cnt;
   logic [3:0]          hi_nib;

   assign buf_if.rd_addr = byte_cnt[BUF_ADDR_W-1:0];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= st_idle;
         busy     <= 1'b0;
         tx_en    <= 1'b0;
         tx_data  <= 4'h0;
         pre_cnt  <= '0;
         nbytes_q <= '0;
         byte_cnt <= '0;
      end else begin
         case (state)
            st_idle: begin
               // busy stays up one more cycle while the last nibble is out
               tx_en   <= 1'b0;
               tx_data <= 4'h0;
               busy    <= 1'b0;
               if (send && !busy && nbytes != '0) begin
                  busy     <= 1'b1;
                  nbytes_q <= nbytes;
                  byte_cnt <= '0;
                  pre_cnt  <= '0;
                  state    <= st_preamble;
               end
            end
            st_preamble: begin
               tx_en   <= 1'b1;
               tx_data <= mii_preamble;
               pre_cnt <= pre_cnt + 1'b1;
               if (pre_cnt == 4'(preamble_nibbles - 1)) state <= st_sfd;
            end
            st_sfd: begin
               tx_data <= mii_sfd;
               state   <= st_low;
            end
            st_low: begin
               tx_data  <= buf_if.rd_data[3:0];
               byte_cnt <= byte_cnt + 1'b1;
               state    <= st_high;
            end
            st_high: begin
               tx_data <= hi_nib;
               state   <= (byte_cnt == nbytes_q) ? st_idle : st_low;
            end
            default: state <= st_idle;
         endcase
      end
   end

   // upper nibble kept while the next byte is fetched
   always_ff @(posedge clk) begin
      if (state == st_low) hi_nib <= buf_if.rd_data[7:4];
   end

   assert property (@(posedge clk) disable iff (rst) !busy |-> !tx_en);

   assert property (@(posedge clk) disable iff (rst) busy |-> byte_cnt <= nbytes_q);

endmodule

// ==== source/eth_pkg.sv ====
package eth_pkg;

   // host bus widths
   localparam int host_addr_w = 12;
   localparam int host_data_w = 32;

   // frame length counter, up to 2047 bytes
   localparam int nbytes_w = 11;

   // register map
   // top address bit selects the packet buffer window instead
   localparam logic [host_addr_w-1:0] reg_status    = 12'd0;
   localparam logic [host_addr_w-1:0] reg_control   = 12'd1;
   localparam logic [host_addr_w-1:0] reg_scratch   = 12'd4;
   localparam logic [host_addr_w-1:0] reg_tx_nbytes = 12'd5;
   localparam logic [host_addr_w-1:0] reg_rx_nbytes = 12'd6;

   // mii nibble values
   localparam logic [3:0] mii_preamble = 4'h5;
   localparam logic [3:0] mii_sfd      = 4'hd;
   localparam int preamble_nibbles     = 15;

   // one host write word seen as control bits or as a byte count
   typedef union packed {
      struct packed {
         logic [host_data_w-3:0] unused;
         logic                   receive;
         logic                   send;
      } ctrl;
      struct packed {
         logic [host_data_w-nbytes_w-1:0] unused;
         logic [nbytes_w-1:0]             nbytes;
      } count;
   } host_word_u;

endpackage

// ==== source/eth_pkt_buf.sv ====
module eth_pkt_buf #(
   parameter int BUF_ADDR_W = 11
) (
   input  logic  clk,
   eth_buf_if.mem buf_if
);

   localparam int depth = 2 ** BUF_ADDR_W;

   logic [7:0] mem [depth];

   // write port
   always_ff @(posedge clk) begin
      if (buf_if.wr_en) begin
         mem[buf_if.wr_addr] <= buf_if.wr_data;
      end
   end

   // synchronous read on every edge
   always_ff @(posedge clk) begin
      buf_if.rd_data <= mem[buf_if.rd_addr];
   end

endmodule

// ==== test/eth_core_tb.sv ====
module eth_core_tb
   import eth_pkg::*;
();

   localparam int max_bytes = 64;
   localparam int n_frames  = 13;
   // per frame, host loading or readback plus the nibble stream and polling
   localparam int watchdog_cycles = n_frames * (5 * max_bytes + 64) + 200;
   localparam logic [host_addr_w-1:0] buf_base = 12'h800;

   logic                   clk;
   logic                   rst;
   logic                   sel;
   logic                   we;
   logic [host_addr_w-1:0] addr;
   logic [host_data_w-1:0] data_in;
   logic [host_data_w-1:0] data_out;
   logic                   phy_resetn;
   logic                   rx_dv;
   logic [3:0]             rx_data;
   logic                   tx_en;
   logic [3:0]             tx_data;

   logic [31:0] lfsr_state = 32'h3d216306;
   logic [7:0]  tx_bytes [max_bytes];
   logic [7:0]  rx_bytes [max_bytes];
   logic [7:0]  rx_mirror [max_bytes];
   logic [3:0]  cap_q [$];
   logic [3:0]  exp_q [$];
   logic        tx_en_prev = 1'b0;
   int          frames_captured = 0;
   int          frames_checked = 0;
   int          tx_sent = 0;
   int          tx_len = 0;

   eth_core #(.PHY_RST_CYCLES(16)) dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // 15 preamble nibbles, sfd, then each byte low nibble first
   function automatic void expected_tx_stream(input int n);
      exp_q.delete();
      for (int i = 0; i < 15; i++) exp_q.push_back(4'h5);
      exp_q.push_back(4'hd);
      for (int i = 0; i < n; i++) begin
         exp_q.push_back(tx_bytes[i][3:0]);
         exp_q.push_back(tx_bytes[i][7:4]);
      end
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
         $display("TEST RESULT: FAIL");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic host_write(input logic [host_addr_w-1:0] a, input logic [host_data_w-1:0] d);
      @(negedge clk);
      sel = 1'b1;
      we = 1'b1;
      addr = a;
      data_in = d;
      @(negedge clk);
      sel = 1'b0;
      we = 1'b0;
   endtask

   // data_out is sampled at the second falling edge after the request
   task automatic host_read(input logic [host_addr_w-1:0] a, output logic [host_data_w-1:0] d);
      @(negedge clk);
      sel = 1'b1;
      we = 1'b0;
      addr = a;
      @(negedge clk);
      sel = 1'b0;
      @(negedge clk);
      d = data_out;
   endtask

   task automatic write_count(input logic [host_addr_w-1:0] a, input int n);
      host_word_u w;
      w = '0;
      w.count.nbytes = nbytes_w'(n);
      host_write(a, w);
   endtask

   task automatic write_control(input logic do_send, input logic do_receive);
      host_word_u w;
      w = '0;
      w.ctrl.send = do_send;
      w.ctrl.receive = do_receive;
      host_write(reg_control, w);
   endtask

   task automatic wait_ready(input int bit_idx);
      logic [31:0] st;
      st = '0;
      while (!st[bit_idx]) host_read(reg_status, st);
   endtask

   task automatic drive_rx_frame(input int n);
      @(negedge clk);
      rx_dv = 1'b1;
      for (int i = 0; i < 15; i++) begin
         rx_data = 4'h5;
         @(negedge clk);
      end
      rx_data = 4'hd;
      for (int i = 0; i < n; i++) begin
         @(negedge clk);
         rx_data = rx_bytes[i][3:0];
         @(negedge clk);
         rx_data = rx_bytes[i][7:4];
      end
      @(negedge clk);
      rx_dv = 1'b0;
      rx_data = 4'h0;
   endtask

   task automatic run_tx(input int n);
      for (int i = 0; i < n; i++) begin
         tx_bytes[i] = 8'(rand_bits(8));
         host_write(buf_base + 12'(i), {24'h0, tx_bytes[i]});
      end
      tx_len = n;
      tx_sent++;
      write_count(reg_tx_nbytes, n);
      write_control(1'b1, 1'b0);
      wait_ready(0);
      wait (frames_checked == tx_sent);
   endtask

   // bytes past n_drive keep what an earlier frame left there
   task automatic run_rx(input int n_arm, input int n_drive);
      logic [31:0] d;
      for (int i = 0; i < n_drive; i++) rx_bytes[i] = 8'(rand_bits(8));
      write_count(reg_rx_nbytes, n_arm);
      write_control(1'b0, 1'b1);
      drive_rx_frame(n_drive);
      wait_ready(1);
      for (int i = 0; i < n_drive; i++) rx_mirror[i] = rx_bytes[i];
      for (int i = 0; i < n_arm; i++) begin
         host_read(buf_base + 12'(i), d);
         check_value("rx buffer byte", {24'h0, rx_mirror[i]}, d);
      end
   endtask

   // tx nibble capture, a frame ends when tx_en falls
   always @(negedge clk) begin
      if (tx_en === 1'b1) cap_q.push_back(tx_data);
      if (tx_en_prev && tx_en === 1'b0) frames_captured++;
      tx_en_prev = (tx_en === 1'b1);
   end

   initial begin
      forever begin
         wait (frames_captured > frames_checked);
         expected_tx_stream(tx_len);
         check_value("tx_en cycles", 16 + 2 * tx_len, cap_q.size());
         for (int i = 0; i < exp_q.size(); i++) check_value("tx_data", exp_q[i], cap_q[i]);
         cap_q.delete();
         frames_checked++;
      end
   end

   initial begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
      $display("TEST RESULT: FAIL");
      $fatal(1, "watchdog expired");
   end

   initial begin
      logic [31:0] d;
      logic [31:0] word;
      int          n;
      rst = 1'b1;
      sel = 1'b0;
      we = 1'b0;
      addr = '0;
      data_in = '0;
      rx_dv = 1'b0;
      rx_data = 4'h0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      check_value("phy_resetn", 32'h0, phy_resetn);
      host_read(reg_status, d);
      check_value("status", 32'h0, d);
      repeat (12) @(negedge clk);
      check_value("phy_resetn", 32'h0, phy_resetn);
      repeat (2) @(negedge clk);
      check_value("phy_resetn", 32'h1, phy_resetn);
      // phy up and both engines idle sets all three status bits
      host_read(reg_status, d);
      check_value("status", 32'h7, d);

      word = rand_bits(32);
      host_write(reg_scratch, word);
      host_read(reg_scratch, d);
      check_value("scratch", word, d);
      host_read(12'd2, d);
      check_value("unused register", 32'h0, d);

      run_tx(rand_bits(6) + 1);
      n = 8 + rand_bits(3);
      run_rx(n, n);
      run_rx(8, 3);

      for (int r = 0; r < 5; r++) begin
         run_tx(rand_bits(6) + 1);
         n = rand_bits(6) + 1;
         run_rx(n, n);
      end

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule
